//--- vec_config.svh
// Compile-time sizes of the vector unit, included by both packages and by the RTL that needs them
`ifndef VEC_CONFIG_SVH
`define VEC_CONFIG_SVH

////////////////////////////////////////
// Array shape
////////////////////////////////////////

// Number of lanes, a power of two
`define VEC_NR_LANES 4

// Width of one element and of the scalar operand
`define VEC_ELEM_W 32

// Vector registers, each lane holds one element of every register
`define VEC_NR_VREGS 8

////////////////////////////////////////
// Flow control
////////////////////////////////////////

// Response FIFO depth
// The dispatcher never lets more instructions than this into the array
`define VEC_RESP_CREDITS 4

`endif

//--- vec_isa_pkg.sv
// Instruction and response types on the host channels, imported by the dispatcher, lanes and reducer
`include "vec_config.svh"

package vec_isa_pkg;

  // One vector element
  // Also used for the scalar operand and the reduced result
  typedef logic [`VEC_ELEM_W-1:0] elem_t;

  // Vector register number
  typedef logic [$clog2(`VEC_NR_VREGS)-1:0] vreg_idx_t;

  // Supported operations
  typedef enum logic [1:0] {
    OP_SPLAT  = 2'd0,  // vd gets scalar plus lane number
    OP_VADD   = 2'd1,
    OP_VXOR   = 2'd2,
    OP_REDSUM = 2'd3   // adds up vs1 over all lanes without a write
  } vec_op_e;

  ////////////////////////////////////////
  // Host channels
  ////////////////////////////////////////

  // Request from the host
  typedef struct packed {
    vec_op_e   op;
    vreg_idx_t vd;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    elem_t     scalar;
  } vec_req_t;

  // One response per instruction, in request order
  typedef struct packed {
    vreg_idx_t vd;
    elem_t     result;
  } vec_resp_t;

endpackage : vec_isa_pkg

//--- vec_lane_pkg.sv
// Types passed between dispatcher, lanes and reducer inside the vector array
`include "vec_config.svh"

package vec_lane_pkg;

  // Position of a lane in the array
  typedef logic [$clog2(`VEC_NR_LANES)-1:0] lane_id_t;

  ////////////////////////////////////////
  // Broadcast and result
  ////////////////////////////////////////

  // Copy of the accepted request as every lane sees it
  typedef struct packed {
    vec_isa_pkg::vec_op_e   op;
    vec_isa_pkg::vreg_idx_t vd;
    vec_isa_pkg::vreg_idx_t vs1;
    vec_isa_pkg::vreg_idx_t vs2;
    vec_isa_pkg::elem_t     scalar;
  } lane_req_t;

  // Element one lane hands to the adder tree
  // vd rides along so the response can echo it
  typedef struct packed {
    vec_isa_pkg::elem_t     elem;
    vec_isa_pkg::vreg_idx_t vd;
  } lane_res_t;

endpackage : vec_lane_pkg

//--- vec_dispatcher.sv
// Front end of the vector unit, takes host requests under credit control and feeds all lanes
`include "vec_config.svh"

module vec_dispatcher (
  // Clock and reset
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  // Host request channel
  input  vec_isa_pkg::vec_req_t   req_i,
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  // Broadcast to the lanes
  output vec_lane_pkg::lane_req_t lane_req_o,
  output logic                    lane_req_valid_o,
  // Pop of the response FIFO
  input  logic                    credit_return_i
);

  localparam int unsigned CREDITS = `VEC_RESP_CREDITS;
  localparam int unsigned CNT_W   = $clog2(CREDITS + 1);

  ////////////////////////////////////////
  // Credit counter
  ////////////////////////////////////////

  // Instructions in lanes, adder tree or response FIFO
  logic [CNT_W-1:0] outstanding_q;
  logic             accept;

  assign req_ready_o = (outstanding_q != CNT_W'(CREDITS));
  assign accept      = req_valid_i & req_ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      outstanding_q <= '0;
    end else begin
      case ({accept, credit_return_i})
        2'b10:   outstanding_q <= outstanding_q + 1'b1;
        2'b01:   outstanding_q <= outstanding_q - 1'b1;
        default: outstanding_q <= outstanding_q;
      endcase
    end
  end

  ////////////////////////////////////////
  // Broadcast register
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lane_req_valid_o <= 1'b0;
    end else begin
      lane_req_valid_o <= accept;
    end
  end

  // Lanes always accept, so the copy lives for one cycle only
  always_ff @(posedge clk_i) begin
    if (accept) begin
      lane_req_o.op     <= req_i.op;
      lane_req_o.vd     <= req_i.vd;
      lane_req_o.vs1    <= req_i.vs1;
      lane_req_o.vs2    <= req_i.vs2;
      lane_req_o.scalar <= req_i.scalar;
    end
  end

  // Returned credits and accepted requests must balance
  a_credit_bound: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    outstanding_q <= CNT_W'(CREDITS))
    else $error("vec_dispatcher: more instructions in flight than credits");

  a_credit_underflow: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    credit_return_i |-> (outstanding_q != '0))
    else $error("vec_dispatcher: credit returned with nothing in flight");

endmodule : vec_dispatcher

//--- vec_lane.sv
// One vector lane, holds its element of every register and executes the broadcast operation
`include "vec_config.svh"

module vec_lane (
  // Clock and reset
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  // Position in the array
  input  vec_lane_pkg::lane_id_t  lane_id_i,
  // From the dispatcher
  input  vec_lane_pkg::lane_req_t lane_req_i,
  input  logic                    lane_req_valid_i,
  // To the reducer
  output vec_lane_pkg::lane_res_t lane_res_o,
  output logic                    lane_res_valid_o
);

  import vec_isa_pkg::*;

  localparam int unsigned NR_VREGS = `VEC_NR_VREGS;

  ////////////////////////////////////////
  // Register file slice
  ////////////////////////////////////////

  elem_t vrf_q [NR_VREGS];
  elem_t op_a;
  elem_t op_b;
  elem_t elem_d;
  logic  wr_en;

  assign op_a = vrf_q[lane_req_i.vs1];
  assign op_b = vrf_q[lane_req_i.vs2];

  // Elementwise execute
  always_comb begin
    case (lane_req_i.op)
      OP_SPLAT:  elem_d = lane_req_i.scalar + elem_t'(lane_id_i);
      OP_VADD:   elem_d = op_a + op_b;
      OP_VXOR:   elem_d = op_a ^ op_b;
      OP_REDSUM: elem_d = op_a;
      default:   elem_d = '0;
    endcase
  end

  // Reductions only read
  assign wr_en = lane_req_valid_i && (lane_req_i.op != OP_REDSUM);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < NR_VREGS; i++) begin
        vrf_q[i] <= '0;
      end
    end else if (wr_en) begin
      vrf_q[lane_req_i.vd] <= elem_d;
    end
  end

  ////////////////////////////////////////
  // Result register
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lane_res_valid_o <= 1'b0;
    end else begin
      lane_res_valid_o <= lane_req_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (lane_req_valid_i) begin
      lane_res_o.elem <= elem_d;
      lane_res_o.vd   <= lane_req_i.vd;
    end
  end

  // Broadcast from the dispatcher must carry a defined opcode
  a_known_op: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    lane_req_valid_i |-> !$isunknown(lane_req_i.op))
    else $error("vec_lane: unknown opcode on a valid request");

endmodule : vec_lane

//--- vec_reducer.sv
// Back end of the vector unit, sums the lane elements and queues one response per instruction
`include "vec_config.svh"

module vec_reducer (
  // Clock and reset
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  // From the lanes, in lockstep
  input  vec_lane_pkg::lane_res_t lane_res_i [`VEC_NR_LANES],
  input  logic                    lane_res_valid_i,
  // Host response channel
  output vec_isa_pkg::vec_resp_t  resp_o,
  output logic                    resp_valid_o,
  input  logic                    resp_ready_i,
  // To the dispatcher
  output logic                    credit_return_o
);

  import vec_isa_pkg::*;

  localparam int unsigned NR_LANES = `VEC_NR_LANES;
  localparam int unsigned NR_PAIRS = NR_LANES / 2;
  localparam int unsigned DEPTH    = `VEC_RESP_CREDITS;
  localparam int unsigned PTR_W    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W    = $clog2(DEPTH + 1);

  ////////////////////////////////////////
  // Adder tree
  ////////////////////////////////////////

  // First stage adds neighbouring lanes
  elem_t     pair_q [NR_PAIRS];
  vreg_idx_t s1_vd_q;
  logic      s1_valid_q;
  elem_t     tree_sum;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      s1_valid_q <= 1'b0;
    end else begin
      s1_valid_q <= lane_res_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (lane_res_valid_i) begin
      for (int p = 0; p < NR_PAIRS; p++) begin
        pair_q[p] <= lane_res_i[2*p].elem + lane_res_i[2*p+1].elem;
      end
      s1_vd_q <= lane_res_i[0].vd;
    end
  end

  // Second stage folds the pair sums, registered by the FIFO write
  always_comb begin
    tree_sum = '0;
    for (int p = 0; p < NR_PAIRS; p++) begin
      tree_sum = tree_sum + pair_q[p];
    end
  end

  ////////////////////////////////////////
  // Response FIFO
  ////////////////////////////////////////

  vec_resp_t        fifo_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign push            = s1_valid_q;
  assign pop             = resp_valid_o & resp_ready_i;
  assign resp_valid_o    = (count_q != '0);
  assign resp_o          = fifo_q[rd_ptr_q];
  // Every response frees one slot in the array
  assign credit_return_o = pop;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_q[wr_ptr_q].vd     <= s1_vd_q;
      fifo_q[wr_ptr_q].result <= tree_sum;
    end
  end

  // Dispatcher credits keep the FIFO from overflowing
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    push |-> (count_q != CNT_W'(DEPTH)))
    else $error("vec_reducer: push into a full response FIFO");

endmodule : vec_reducer

//--- vec_unit.sv
// Top of the vector coprocessor, ties dispatcher, lane array and reducer to the host channels
`include "vec_config.svh"

module vec_unit (
  // Clock and reset
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  // Host request channel
  input  vec_isa_pkg::vec_req_t  req_i,
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  // Host response channel
  output vec_isa_pkg::vec_resp_t resp_o,
  output logic                   resp_valid_o,
  input  logic                   resp_ready_i
);

  import vec_lane_pkg::*;

  localparam int unsigned NR_LANES = `VEC_NR_LANES;

  lane_req_t           lane_req;
  logic                lane_req_valid;
  lane_res_t           lane_res [NR_LANES];
  logic                lane_res_valid;
  logic                credit_return;

  ////////////////////////////////////////
  // Dispatcher
  ////////////////////////////////////////

  vec_dispatcher u_dispatcher (
    .clk_i            (clk_i         ),
    .arst_n_i         (arst_n_i      ),
    .req_i            (req_i         ),
    .req_valid_i      (req_valid_i   ),
    .req_ready_o      (req_ready_o   ),
    .lane_req_o       (lane_req      ),
    .lane_req_valid_o (lane_req_valid),
    .credit_return_i  (credit_return )
  );

  ////////////////////////////////////////
  // Lanes
  ////////////////////////////////////////

  // Lanes move in lockstep, so only lane 0 reports a valid
  for (genvar i = 0; i < NR_LANES; i++) begin : gen_lanes
    if (i == 0) begin : gen_lead
      vec_lane u_lane (
        .clk_i            (clk_i         ),
        .arst_n_i         (arst_n_i      ),
        .lane_id_i        (lane_id_t'(i) ),
        .lane_req_i       (lane_req      ),
        .lane_req_valid_i (lane_req_valid),
        .lane_res_o       (lane_res[i]   ),
        .lane_res_valid_o (lane_res_valid)
      );
    end else begin : gen_follow
      vec_lane u_lane (
        .clk_i            (clk_i         ),
        .arst_n_i         (arst_n_i      ),
        .lane_id_i        (lane_id_t'(i) ),
        .lane_req_i       (lane_req      ),
        .lane_req_valid_i (lane_req_valid),
        .lane_res_o       (lane_res[i]   ),
        .lane_res_valid_o (              )
      );
    end
  end : gen_lanes

  // Reducer trusts lane 0 for all lanes
  vec_reducer u_reducer (
    .clk_i            (clk_i         ),
    .arst_n_i         (arst_n_i      ),
    .lane_res_i       (lane_res      ),
    .lane_res_valid_i (lane_res_valid),
    .resp_o           (resp_o        ),
    .resp_valid_o     (resp_valid_o  ),
    .resp_ready_i     (resp_ready_i  ),
    .credit_return_o  (credit_return )
  );

  if (NR_LANES < 2 || NR_LANES != 2 ** $clog2(NR_LANES)) begin : gen_lane_check
    $error("vec_unit: the lane count must be a power of two and at least two");
  end

endmodule : vec_unit

//--- tb_clk_gen.sv
// Clock and reset source of the vector unit testbench, instantiated once by the testbench top
module tb_clk_gen (
  output logic clk_o,
  output logic arst_n_o
);

  // Period of 20
  initial begin
    clk_o = 1'b0;
    forever begin
      #10 clk_o = ~clk_o;
    end
  end

  // Reset held low over the first two rising edges
  initial begin
    arst_n_o = 1'b0;
    repeat (2) @(posedge clk_o);
    #2 arst_n_o = 1'b1;
  end

endmodule : tb_clk_gen

//--- tb_vec_unit.sv
// Self-checking testbench of the vector unit, runs a request table against a register model
`include "vec_config.svh"

module tb_vec_unit;

  import vec_isa_pkg::*;

  localparam int NR_LANES = `VEC_NR_LANES;
  localparam int NR_VREGS = `VEC_NR_VREGS;

  typedef enum logic [1:0] {
    MODE_SEQ,    // one request at a time
    MODE_BURST,  // back to back, responses always taken
    MODE_STALL,  // responses held until the credits run out
    MODE_RAND    // responses taken at random
  } tb_mode_e;

  typedef struct packed {
    tb_mode_e  mode;
    vec_req_t  req;
    vec_resp_t exp;
  } entry_t;

  logic        clk;
  logic        arst_n;
  vec_req_t    req;
  logic        req_valid;
  logic        req_ready;
  vec_resp_t   resp;
  logic        resp_valid;
  logic        resp_ready;

  entry_t      tab [$];
  elem_t       model_rf [NR_VREGS][NR_LANES];
  logic [31:0] lcg_state = 32'd99949;
  tb_mode_e    cur_mode = MODE_SEQ;
  bit          tab_built = 1'b0;
  int          tx_cnt = 0;
  int          rx_cnt = 0;
  int          err_result = 0;
  int          err_vd = 0;
  int          err_other = 0;

  tb_clk_gen u_clk_gen (
    .clk_o    (clk   ),
    .arst_n_o (arst_n)
  );

  vec_unit u_dut (
    .clk_i        (clk       ),
    .arst_n_i     (arst_n    ),
    .req_i        (req       ),
    .req_valid_i  (req_valid ),
    .req_ready_o  (req_ready ),
    .resp_o       (resp      ),
    .resp_valid_o (resp_valid),
    .resp_ready_i (resp_ready)
  );

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Applies one instruction to the model, returns the expected response
  function automatic vec_resp_t model_step(input vec_req_t r);
    elem_t     e;
    vec_resp_t rsp;
    rsp.vd     = r.vd;
    rsp.result = '0;
    for (int l = 0; l < NR_LANES; l++) begin
      case (r.op)
        OP_SPLAT: e = r.scalar + elem_t'(l);
        OP_VADD:  e = model_rf[r.vs1][l] + model_rf[r.vs2][l];
        OP_VXOR:  e = model_rf[r.vs1][l] ^ model_rf[r.vs2][l];
        default:  e = model_rf[r.vs1][l];
      endcase
      if (r.op != OP_REDSUM) begin
        model_rf[r.vd][l] = e;
      end
      rsp.result = rsp.result + e;
    end
    return rsp;
  endfunction

  task automatic add_entry(input tb_mode_e mode, input vec_op_e op, input vreg_idx_t vd,
                           input vreg_idx_t vs1, input vreg_idx_t vs2, input elem_t scalar);
    entry_t e;
    e.mode       = mode;
    e.req.op     = op;
    e.req.vd     = vd;
    e.req.vs1    = vs1;
    e.req.vs2    = vs2;
    e.req.scalar = scalar;
    e.exp        = model_step(e.req);
    tab.push_back(e);
  endtask

  task automatic build_table();
    logic [31:0] rnd;
    for (int r = 0; r < NR_VREGS; r++) begin
      for (int l = 0; l < NR_LANES; l++) begin
        model_rf[r][l] = '0;
      end
    end
    // Reset contents, splats and arithmetic one at a time
    add_entry(MODE_SEQ, OP_REDSUM, 3'd3, 3'd3, 3'd0, '0);
    add_entry(MODE_SEQ, OP_SPLAT, 3'd1, 3'd0, 3'd0, 32'd5);
    add_entry(MODE_SEQ, OP_SPLAT, 3'd2, 3'd0, 3'd0, lcg_next());
    add_entry(MODE_SEQ, OP_SPLAT, 3'd3, 3'd0, 3'd0, 32'hffff_ffff);
    add_entry(MODE_SEQ, OP_VADD, 3'd4, 3'd1, 3'd2, '0);
    add_entry(MODE_SEQ, OP_VXOR, 3'd5, 3'd4, 3'd3, '0);
    add_entry(MODE_SEQ, OP_REDSUM, 3'd0, 3'd5, 3'd0, '0);
    // Back to back, each reads what the one before wrote
    add_entry(MODE_BURST, OP_SPLAT, 3'd6, 3'd0, 3'd0, lcg_next());
    add_entry(MODE_BURST, OP_VADD, 3'd7, 3'd6, 3'd1, '0);
    add_entry(MODE_BURST, OP_VXOR, 3'd0, 3'd7, 3'd5, '0);
    add_entry(MODE_BURST, OP_REDSUM, 3'd2, 3'd0, 3'd0, '0);
    add_entry(MODE_BURST, OP_VADD, 3'd7, 3'd7, 3'd7, '0);
    add_entry(MODE_BURST, OP_REDSUM, 3'd1, 3'd7, 3'd0, '0);
    // Four fill the credits, the fifth has to wait
    add_entry(MODE_STALL, OP_SPLAT, 3'd2, 3'd0, 3'd0, lcg_next());
    add_entry(MODE_STALL, OP_VADD, 3'd3, 3'd2, 3'd2, '0);
    add_entry(MODE_STALL, OP_REDSUM, 3'd4, 3'd3, 3'd0, '0);
    add_entry(MODE_STALL, OP_VXOR, 3'd1, 3'd3, 3'd0, '0);
    add_entry(MODE_STALL, OP_SPLAT, 3'd6, 3'd0, 3'd0, lcg_next());
    for (int k = 0; k < 40; k++) begin
      rnd = lcg_next();
      add_entry(MODE_RAND, vec_op_e'(rnd[31:30]), rnd[29:27], rnd[26:24], rnd[23:21],
                lcg_next());
    end
  endtask

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  task automatic check_result(input elem_t exp, input elem_t got);
    if (got !== exp) begin
      $display("[ERROR] resp.result expected %h got %h (response %0d)", exp, got, rx_cnt);
      err_result++;
    end
  endtask

  task automatic check_vd(input vreg_idx_t exp, input vreg_idx_t got);
    if (got !== exp) begin
      $display("[ERROR] resp.vd expected %h got %h (response %0d)", exp, got, rx_cnt);
      err_vd++;
    end
  endtask

  task automatic report_fault(input string msg);
    $display("Failure at %0t: %s", $time, msg);
    err_other++;
  endtask

  ////////////////////////////////////////
  // Request side
  ////////////////////////////////////////

  // Entered and left 2 units after a rising edge
  task automatic send(input vec_req_t r);
    req       = r;
    req_valid = 1'b1;
    while (!req_ready) begin
      @(posedge clk);
      #2;
    end
    @(posedge clk);
    #2;
    req_valid = 1'b0;
    tx_cnt++;
  endtask

  task automatic hold_blocked(input vec_req_t r);
    if (req_ready) begin
      report_fault("req_ready_o still high with 4 requests outstanding");
    end
    req       = r;
    req_valid = 1'b1;
    repeat (6) begin
      @(posedge clk);
      #2;
      if (req_ready) begin
        report_fault("request accepted while all credits were in use");
      end
    end
  endtask

  initial begin
    entry_t e;
    int     stall_cnt;
    req        = '0;
    req_valid  = 1'b0;
    resp_ready = 1'b1;
    stall_cnt  = 0;
    build_table();
    tab_built = 1'b1;
    @(posedge arst_n);
    @(posedge clk);
    #2;
    if (resp_valid) begin
      report_fault("resp_valid_o high after reset");
    end
    if (!req_ready) begin
      report_fault("req_ready_o low after reset");
    end
    for (int i = 0; i < tab.size(); i++) begin
      e = tab[i];
      // New phase starts with the array empty
      if (i == 0 || e.mode != tab[i-1].mode) begin
        wait (rx_cnt == tx_cnt);
        @(negedge clk);
        cur_mode = e.mode;
        @(posedge clk);
        #2;
        // The random phase leaves resp_ready_i to the back-pressure process
        if (e.mode != MODE_RAND) begin
          resp_ready = (e.mode != MODE_STALL);
        end
      end
      if (e.mode == MODE_STALL) begin
        if (stall_cnt == 4) begin
          hold_blocked(e.req);
          resp_ready = 1'b1;
        end else if (!req_ready) begin
          report_fault("req_ready_o low before 4 requests were outstanding");
        end
        stall_cnt++;
      end
      send(e.req);
      if (e.mode == MODE_SEQ) begin
        wait (rx_cnt == tx_cnt);
        @(posedge clk);
        #2;
      end
    end
    wait (rx_cnt == tx_cnt);
    @(negedge clk);
    cur_mode = MODE_SEQ;
    @(posedge clk);
    #2;
    resp_ready = 1'b1;
    // Room for a stray extra response
    repeat (8) @(posedge clk);
    if (rx_cnt != tab.size()) begin
      report_fault($sformatf("%0d responses for %0d requests", rx_cnt, tab.size()));
    end
    $display("Responses %0d of %0d, errors: result %0d, vd %0d, other %0d",
             rx_cnt, tab.size(), err_result, err_vd, err_other);
    if (err_result + err_vd + err_other == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  ////////////////////////////////////////
  // Response side
  ////////////////////////////////////////

  // Random back-pressure only in the last phase
  initial begin
    logic [31:0] rnd;
    forever begin
      @(posedge clk);
      #2;
      if (cur_mode == MODE_RAND) begin
        rnd        = lcg_next();
        resp_ready = rnd[28];
      end
    end
  end

  // A handshake seen at the falling edge completes on the next rising edge
  initial begin
    forever begin
      @(negedge clk);
      if (resp_valid && resp_ready) begin
        if (rx_cnt >= tab.size()) begin
          report_fault("response received with no request left");
        end else begin
          check_vd(tab[rx_cnt].exp.vd, resp.vd);
          check_result(tab[rx_cnt].exp.result, resp.result);
        end
        rx_cnt++;
      end
    end
  end

  // Watchdog
  initial begin
    wait (tab_built);
    #((tab.size() + 50) * 20 * 4);
    $display("Run timed out with %0d requests sent and %0d responses, errors: %0d",
             tx_cnt, rx_cnt, err_result + err_vd + err_other);
    $display("Checks failed");
    $finish;
  end

endmodule : tb_vec_unit

//--- compile.f
+incdir+.
vec_isa_pkg.sv
vec_lane_pkg.sv
vec_dispatcher.sv
vec_lane.sv
vec_reducer.sv
vec_unit.sv
tb_clk_gen.sv
tb_vec_unit.sv

//--- Makefile
SRCS := $(filter-out +incdir+%,$(shell cat compile.f))

obj_dir/Vtb_vec_unit: compile.f $(SRCS) vec_config.svh
	verilator --binary --timing -Wno-fatal --top-module tb_vec_unit -f compile.f

run: obj_dir/Vtb_vec_unit
	@out="$$(./obj_dir/Vtb_vec_unit)"; echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf obj_dir

.PHONY: run clean
